/* run.sh */
#!/usr/bin/env bash
# build and run the receive monitor testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--timescale 1ns/1ps \
	--top-module tb_lmac_rx_monitor \
	-Mdir obj_dir -o tb_sim \
	-f tb.f

./obj_dir/tb_sim 2>&1 | tee sim.log

if grep -q "Testbench failed" sim.log; then
	echo "simulation reported failure"
	exit 1
fi

exit 0

/* sim/tb_lmac_rx_monitor.sv */
// table driven testbench for the receive monitor, each table row is read back after it settles
// rows in 25G mode hold their beat for four clocks so exactly one copy is sampled
`default_nettype none
`include "lmac_defs.svh"

module tb_lmac_rx_monitor
	import lmac_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int          NUM_ENTRIES = 27;
	localparam int          RD_TIMEOUT  = 20;              // cycles per wait for done
	localparam logic [31:0] RAND_SEED   = 32'h26bf7b4a;
	localparam logic [31:0] NO_LANE     = 32'd0;
	localparam logic [31:0] ALIGNED     = 32'h1111_1111;   // bytes 0, 4, 8 .. 28
	localparam sys_addr_t   SYS_ADDR    = 4'h3;
	localparam reg_word_t   CTRL_BASE   = 32'h0000_1234;   // bit 7 clear
	localparam reg_word_t   CTRL_B2B    = 32'h5a5a_0c21;
	localparam reg_word_t   AUTO_CLR    = 32'd1 << `LMAC_CTRL_RX_AUTO_CLR;

	typedef struct packed {
		logic        is_25g;
		logic        en;          // fmac_rxd_en level
		logic        clr;         // control bit 7
		logic [31:0] sof_lanes;   // byte positions holding 0xFB
		logic [31:0] eof_lanes;   // byte positions holding 0xFD
		logic [30:0] exp_cnt;
		logic        exp_sticky;
	} entry_t;

	logic        clk;
	logic        reset_;
	logic        mode_25g;
	cgmii_data_t cgmii_rxd;
	cgmii_ctrl_t cgmii_rxc;
	logic        fmac_rxd_en;
	reg_word_t   fmac_ctrl;
	logic        reg_rd_start;
	host_addr_t  host_addr;
	sys_addr_t   sys_addr;
	logic        reg_rd_done;
	reg_word_t   fmac_regdout;

	entry_t      tbl [NUM_ENTRIES];
	int          errors;
	logic        timed_out;
	int          cyc;                // rising edges since time 0
	logic [31:0] seed_ret;

	// reference model state
	logic        m_open;
	logic [30:0] m_cnt;
	logic        m_sticky;

	// reads in flight, oldest first
	reg_word_t   exp_q  [$];
	int          edge_q [$];
	string       name_q [$];

	lmac_rx_monitor_top i_dut (
		.clk          (clk),
		.reset_       (reset_),
		.mode_25g     (mode_25g),
		.cgmii_rxd    (cgmii_rxd),
		.cgmii_rxc    (cgmii_rxc),
		.fmac_rxd_en  (fmac_rxd_en),
		.fmac_ctrl    (fmac_ctrl),
		.reg_rd_start (reg_rd_start),
		.host_addr    (host_addr),
		.sys_addr     (sys_addr),
		.reg_rd_done  (reg_rd_done),
		.fmac_regdout (fmac_regdout)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;            // 8 ns period
	end

	always @(posedge clk)
		cyc <= cyc + 1;

	task automatic next_cycle;
		@(posedge clk);
		#1;                               // drive and sample away from the edge
	endtask

	task automatic check_value(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			$display("ERROR at %0t: %s actual %h expected %h", $time, name, actual, expected);
			errors++;
		end
	endtask

	function automatic logic [31:0] lane_bit(input int n);
		return 32'd1 << n;
	endfunction

	function automatic entry_t make_entry(input int is_25g, input int en, input int clr,
			input logic [31:0] sof, input logic [31:0] eof, input int cnt, input int st);
		entry_t e;
		e.is_25g     = (is_25g != 0);
		e.en         = (en != 0);
		e.clr        = (clr != 0);
		e.sof_lanes  = sof;
		e.eof_lanes  = eof;
		e.exp_cnt    = cnt[30:0];
		e.exp_sticky = (st != 0);
		return e;
	endfunction

	task automatic load_table;
		tbl[0]  = make_entry(0, 1, 0, lane_bit(0),  NO_LANE,      0, 0); // good frame, lane 0
		tbl[1]  = make_entry(0, 1, 0, NO_LANE,      lane_bit(10), 0, 0);
		tbl[2]  = make_entry(0, 1, 0, lane_bit(16), NO_LANE,      0, 0); // good frame, lane 16
		tbl[3]  = make_entry(0, 1, 0, NO_LANE,      lane_bit(31), 0, 0);
		tbl[4]  = make_entry(0, 1, 0, NO_LANE,      lane_bit(5),  1, 0); // terminate, no frame
		tbl[5]  = make_entry(0, 1, 0, lane_bit(0),  NO_LANE,      1, 0);
		tbl[6]  = make_entry(0, 1, 0, lane_bit(8),  NO_LANE,      2, 0); // second start
		tbl[7]  = make_entry(0, 1, 0, NO_LANE,      lane_bit(3),  2, 0);
		tbl[8]  = make_entry(0, 1, 0, lane_bit(5),  NO_LANE,      2, 1); // misaligned start
		tbl[9]  = make_entry(0, 1, 0, lane_bit(0),  NO_LANE,      2, 1);
		tbl[10] = make_entry(0, 1, 0, NO_LANE,      lane_bit(20), 2, 1);
		tbl[11] = make_entry(0, 0, 0, NO_LANE,      NO_LANE,      0, 1); // receive off
		tbl[12] = make_entry(0, 1, 0, NO_LANE,      NO_LANE,      0, 1); // count restarts
		tbl[13] = make_entry(0, 1, 1, NO_LANE,      lane_bit(1),  1, 1); // auto clear masks
		tbl[14] = make_entry(0, 1, 0, NO_LANE,      NO_LANE,      1, 1);
		tbl[15] = make_entry(1, 1, 0, lane_bit(0),  NO_LANE,      1, 1); // 25G from here
		tbl[16] = make_entry(1, 1, 0, lane_bit(4),  NO_LANE,      2, 1);
		tbl[17] = make_entry(1, 1, 0, NO_LANE,      lane_bit(12), 2, 1);
		tbl[18] = make_entry(1, 1, 0, NO_LANE,      lane_bit(30), 3, 1);
		tbl[19] = make_entry(0, 1, 0, lane_bit(24), lane_bit(2),  4, 1); // stray end, new start
		tbl[20] = make_entry(0, 1, 0, NO_LANE,      lane_bit(7),  4, 1);
		tbl[21] = make_entry(0, 1, 0, lane_bit(0),  NO_LANE,      4, 1);
		tbl[22] = make_entry(0, 1, 0, lane_bit(12), lane_bit(9),  4, 1); // end and start in a beat
		tbl[23] = make_entry(0, 1, 0, NO_LANE,      lane_bit(1),  4, 1);
		tbl[24] = make_entry(0, 1, 0, lane_bit(0),  NO_LANE,      4, 1);
		tbl[25] = make_entry(0, 1, 0, lane_bit(6),  NO_LANE,      5, 1); // misaligned, frame open
		tbl[26] = make_entry(0, 1, 0, NO_LANE,      lane_bit(17), 5, 1);
	endtask

	function automatic logic [7:0] fill_byte;
		logic [31:0] r;
		do
			r = $urandom;
		while (r[7:0] == `LMAC_SOF_CHAR || r[7:0] == `LMAC_EOF_CHAR);
		return r[7:0];
	endfunction

	task automatic drive_beat(input logic [31:0] sof, input logic [31:0] eof);
		logic [31:0] r;
		for (int b = 0; b < 32; b++) begin
			if (sof[b]) begin
				cgmii_rxd[8*b +: 8] = `LMAC_SOF_CHAR;
				cgmii_rxc[b]        = 1'b1;
			end else if (eof[b]) begin
				cgmii_rxd[8*b +: 8] = `LMAC_EOF_CHAR;
				cgmii_rxc[b]        = 1'b1;
			end else begin
				r                   = $urandom;
				cgmii_rxd[8*b +: 8] = fill_byte();
				cgmii_rxc[b]        = r[0];       // control bit on data is harmless
			end
		end
	endtask

	// one sampled beat through the frame rules
	task automatic model_beat(input logic [31:0] sof, input logic [31:0] eof, input logic en);
		logic sof_v;
		logic sof_m;
		logic eof_any;
		logic bad;
		sof_v   = |(sof & ALIGNED);
		sof_m   = |(sof & ~ALIGNED);
		eof_any = |eof;
		bad     = (eof_any && !m_open) || ((sof_v || sof_m) && m_open && !eof_any);
		if (sof_v)
			m_open = 1'b1;
		else if (eof_any)
			m_open = 1'b0;
		if (sof_m)
			m_sticky = 1'b1;
		if (bad)
			m_cnt = m_cnt + 31'd1;
		if (!en)
			m_cnt = '0;                        // held clear while receive is off
	endtask

	task automatic issue_read(input host_addr_t addr, input sys_addr_t sa,
			input reg_word_t exp, input string name);
		reg_rd_start = 1'b1;
		host_addr    = addr;
		sys_addr     = sa;
		exp_q.push_back(exp);
		edge_q.push_back(cyc + 1);             // edge that samples the start
		name_q.push_back(name);
		next_cycle();
		reg_rd_start = 1'b0;
	endtask

	task automatic drain_reads;
		int    waited;
		int    start_edge;
		string name;
		while (exp_q.size() > 0) begin
			waited = 0;
			while (!reg_rd_done && waited < RD_TIMEOUT) begin
				next_cycle();
				waited++;
			end
			if (!reg_rd_done) begin
				$display("timeout: no reg_rd_done within %0d cycles for %s",
					RD_TIMEOUT, name_q[0]);
				errors++;
				timed_out = 1'b1;
				return;
			end
			start_edge = edge_q.pop_front();
			name       = name_q.pop_front();
			// the done seen here is sampled by the next edge
			check_value("reg_rd_done latency", cyc + 1 - start_edge, `LMAC_RD_LATENCY);
			check_value(name, fmac_regdout, exp_q.pop_front());
			next_cycle();
		end
		check_value("reg_rd_done", {31'd0, reg_rd_done}, 32'd0); // single clock pulse
	endtask

	task automatic apply_entry(input int k);
		entry_t    e;
		reg_word_t tbl_read;
		reg_word_t model_read;
		e           = tbl[k];
		mode_25g    = e.is_25g;
		fmac_rxd_en = e.en;
		fmac_ctrl   = e.clr ? (CTRL_BASE | AUTO_CLR) : CTRL_BASE;
		repeat (2) begin                       // let the buffered mode follow
			drive_beat(NO_LANE, NO_LANE);
			next_cycle();
		end
		drive_beat(e.sof_lanes, e.eof_lanes);
		repeat (e.is_25g ? 4 : 1) next_cycle();
		model_beat(e.sof_lanes, e.eof_lanes, e.en);
		repeat (6) begin                       // flags, pulse, counter, register
			drive_beat(NO_LANE, NO_LANE);
			next_cycle();
		end
		tbl_read   = (e.en && !e.clr) ? {e.exp_sticky, e.exp_cnt} : 32'd0;
		model_read = (e.en && !e.clr) ? {m_sticky, m_cnt} : 32'd0;
		if (model_read !== tbl_read) begin
			$display("reference model and table disagree at entry %0d: model %h table %h",
				k, model_read, tbl_read);
			errors++;
		end
		issue_read({SYS_ADDR, `LMAC_REG_BAD_SOF}, SYS_ADDR, tbl_read, "fmac_regdout bad_sof");
		drain_reads();
	endtask

	// five reads on consecutive clocks, all in flight together
	task automatic run_back_to_back;
		reg_word_t bad_now;
		fmac_ctrl = CTRL_B2B;
		repeat (3) next_cycle();
		bad_now = {m_sticky, m_cnt};
		issue_read({SYS_ADDR, `LMAC_REG_BAD_SOF}, SYS_ADDR, bad_now, "fmac_regdout bad_sof");
		issue_read({SYS_ADDR, `LMAC_REG_CTRL}, SYS_ADDR, CTRL_B2B, "fmac_regdout ctrl");
		issue_read({SYS_ADDR, `LMAC_REG_BAD_SOF}, SYS_ADDR ^ 4'h5, 32'd0, "fmac_regdout other mac");
		issue_read({SYS_ADDR, 12'h044}, SYS_ADDR, 32'd0, "fmac_regdout unmapped");
		issue_read({SYS_ADDR, `LMAC_REG_CTRL}, SYS_ADDR, CTRL_B2B, "fmac_regdout ctrl");
		drain_reads();
		if (timed_out)
			return;
		repeat (3) next_cycle();
		check_value("fmac_regdout hold", fmac_regdout, CTRL_B2B);
	endtask

	task automatic run_tests;
		for (int k = 0; k < NUM_ENTRIES; k++) begin
			apply_entry(k);
			if (timed_out)
				return;
		end
		run_back_to_back();
	endtask

	initial begin
		seed_ret     = $urandom(RAND_SEED);
		errors       = 0;
		timed_out    = 1'b0;
		m_open       = 1'b0;
		m_cnt        = '0;
		m_sticky     = 1'b0;
		reset_       = 1'b0;
		mode_25g     = 1'b0;
		cgmii_rxd    = '0;
		cgmii_rxc    = '0;
		fmac_rxd_en  = 1'b0;
		fmac_ctrl    = '0;
		reg_rd_start = 1'b0;
		host_addr    = '0;
		sys_addr     = SYS_ADDR;
		load_table();
		repeat (10) next_cycle();
		reset_ = 1'b1;
		run_tests();
		$display("checks complete, %0d errors", errors);
		if (errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire

/* source/cgmii_delim_detect.sv */
// start/terminate decode on the 256-bit CGMII receive bus, flags one clock after the beat
// in 25G mode only the beat at phase 2 of the four-clock cycle is decoded
`default_nettype none
`include "lmac_defs.svh"

module cgmii_delim_detect
	import lmac_pkg::*;
(
	input  logic        clk,
	input  logic        reset_,
	input  logic        mode_25g,        // level, buffered one clock
	input  cgmii_data_t cgmii_rxd,
	input  cgmii_ctrl_t cgmii_rxc,
	output lane_group_t sof_valid,       // start in byte 0 of the group
	output lane_group_t sof_misaligned,  // start in bytes 1..3 of the group
	output logic        eof_seen         // terminate anywhere in the beat
);

	logic        mode_25g_buf;
	logic [1:0]  phase_25g;
	logic        sample_en;
	cgmii_ctrl_t sof_byte;              // per byte start decode
	cgmii_ctrl_t eof_byte;              // per byte terminate decode
	lane_group_t sof_first;
	lane_group_t sof_other;

	// mode rebuffer and 25G phase counter
	always_ff @(posedge clk) begin
		if (!reset_) begin
			mode_25g_buf <= 1'b0;
			phase_25g    <= 2'd0;
		end else begin
			mode_25g_buf <= mode_25g;
			phase_25g    <= mode_25g_buf ? phase_25g + 2'd1 : 2'd0; // parked at 0 outside 25G
		end
	end

	// every beat outside 25G, one in four inside
	assign sample_en = !mode_25g_buf || (phase_25g == `LMAC_SAMPLE_PHASE_25G);

	always_comb begin
		for (int b = 0; b < $bits(cgmii_ctrl_t); b++) begin
			sof_byte[b] = cgmii_rxc[b] && (cgmii_rxd[8*b +: 8] == `LMAC_SOF_CHAR);
			eof_byte[b] = cgmii_rxc[b] && (cgmii_rxd[8*b +: 8] == `LMAC_EOF_CHAR);
		end
	end

	// fold bytes into lane groups
	always_comb begin
		for (int g = 0; g < $bits(lane_group_t); g++) begin
			sof_first[g] = sof_byte[4*g];          // lanes 0, 4, 8 .. 28
			sof_other[g] = |sof_byte[4*g+1 +: 3];  // any other lane of the group
		end
	end

	// registered flags, no hold-off so repeats count again
	always_ff @(posedge clk) begin
		if (!reset_) begin
			sof_valid      <= '0;
			sof_misaligned <= '0;
			eof_seen       <= 1'b0;
		end else if (sample_en) begin
			sof_valid      <= sof_first;
			sof_misaligned <= sof_other;
			eof_seen       <= |eof_byte;
		end else begin
			sof_valid      <= '0;                 // skipped 25G beats
			sof_misaligned <= '0;
			eof_seen       <= 1'b0;
		end
	end

	// sampled 25G beats are never back to back
	a_25g_no_adjacent_sample: assert property (
		@(posedge clk) disable iff (!reset_)
		(mode_25g_buf && sample_en) |=> !(mode_25g_buf && sample_en)
	) else $error("two adjacent beats sampled in 25G mode");

endmodule

`default_nettype wire

/* source/delay_pipe.sv */
// fixed latency shift register of valid and payload, DEPTH items in flight
// no stall, every item leaves exactly DEPTH clocks after it enters
`default_nettype none

module delay_pipe #(
	parameter type payload_t = logic,
	parameter int  DEPTH     = 4        // at least 1
) (
	input  logic     clk,
	input  logic     reset_,
	input  logic     in_valid,
	input  payload_t in_data,
	output logic     out_valid,
	output payload_t out_data
);

	logic [DEPTH-1:0] vld_q;            // control, cleared by reset
	payload_t         data_q [DEPTH];   // payload only

	always_ff @(posedge clk) begin
		if (!reset_) begin
			vld_q <= '0;
		end else begin
			vld_q[0] <= in_valid;
			for (int i = 1; i < DEPTH; i++)
				vld_q[i] <= vld_q[i-1];
		end
	end

	always_ff @(posedge clk) begin
		data_q[0] <= in_data;
		for (int i = 1; i < DEPTH; i++)
			data_q[i] <= data_q[i-1];
	end

	assign out_valid = vld_q[DEPTH-1];
	assign out_data  = data_q[DEPTH-1];

endmodule

`default_nettype wire

/* source/frame_delim_checker.sv */
// frame open/close tracking on the detector flags and the bad frame counter
// counter clears while receive is disabled, the misaligned sticky bit clears only on reset
`default_nettype none

module frame_delim_checker
	import lmac_pkg::*;
(
	input  logic        clk,
	input  logic        reset_,
	input  logic        fmac_rxd_en,     // receive enable level
	input  logic        rx_auto_clr,     // from the control word
	input  lane_group_t sof_valid,
	input  lane_group_t sof_misaligned,
	input  logic        eof_seen,
	output reg_word_t   bad_sof_reg      // {sticky, count[30:0]}
);

	logic        sof_any;
	logic        has_sof;               // frame open
	logic        bad_nosof;             // terminate with no open frame
	logic        bad_noeof;             // start while frame still open
	logic        misaligned_sticky;
	logic        rxd_en_q;
	logic [30:0] bad_cnt;

	assign sof_any = (|sof_valid) || (|sof_misaligned);

	always_ff @(posedge clk) begin
		if (!reset_) begin
			has_sof           <= 1'b0;
			bad_nosof         <= 1'b0;
			bad_noeof         <= 1'b0;
			misaligned_sticky <= 1'b0;
		end else begin
			// start wins when a terminate and the next start share a beat
			if (|sof_valid)
				has_sof <= 1'b1;
			else if (eof_seen)
				has_sof <= 1'b0;
			bad_nosof <= eof_seen && !has_sof;
			bad_noeof <= sof_any && has_sof && !eof_seen;   // misaligned starts count too
			if (|sof_misaligned)
				misaligned_sticky <= 1'b1;
		end
	end

	// bad frame counter, two clocks after the flags
	always_ff @(posedge clk) begin
		if (!reset_) begin
			rxd_en_q <= 1'b0;
			bad_cnt  <= '0;
		end else begin
			rxd_en_q <= fmac_rxd_en;
			if (!rxd_en_q)
				bad_cnt <= '0;                  // restart from zero on re-enable
			else if (bad_nosof || bad_noeof)
				bad_cnt <= bad_cnt + 31'd1;
		end
	end

	// register view, zeroed while cleared or disabled
	always_ff @(posedge clk) begin
		if (!reset_)
			bad_sof_reg <= '0;
		else if (rx_auto_clr || !fmac_rxd_en)
			bad_sof_reg <= '0;
		else
			bad_sof_reg <= {misaligned_sticky, bad_cnt};
	end

	// at most one bad frame per clock while receive stays on
	a_cnt_single_step: assert property (
		@(posedge clk) disable iff (!reset_)
		rxd_en_q |=> (bad_cnt - $past(bad_cnt)) <= 31'd1
	) else $error("bad frame count jumped by more than one");

endmodule

`default_nettype wire

/* source/lmac_defs.svh */
// receive monitor constants shared by the detector and the register read path
// offsets are the low 12 bits of the host address, bits 15:12 select the MAC
`ifndef LMAC_DEFS_SVH
`define LMAC_DEFS_SVH

// CGMII control characters, valid only with the byte's control bit set
`define LMAC_SOF_CHAR           8'hFB   // start
`define LMAC_EOF_CHAR           8'hFD   // terminate

// 25G keeps one beat in four
`define LMAC_SAMPLE_PHASE_25G   2'd2    // phase count of the kept beat

// host read port
`define LMAC_RD_LATENCY         5       // start to done, in clocks
`define LMAC_REG_CTRL           12'h000 // control word readback
`define LMAC_REG_BAD_SOF        12'h040 // bad frame count and misaligned sticky

// control word bits
`define LMAC_CTRL_RX_AUTO_CLR   7       // rx counters read as zero while set

`endif

/* source/lmac_pkg.sv */
// bus and register types of the receive monitor
// lane groups are 32 bits wide, eight per 256-bit beat
`default_nettype none

package lmac_pkg;

	// CGMII receive beat
	typedef logic [255:0] cgmii_data_t;   // 32 bytes, byte 0 in bits 7:0
	typedef logic [31:0]  cgmii_ctrl_t;   // one control bit per byte

	// per lane group flags
	typedef logic [7:0]   lane_group_t;   // bit g covers bytes 4g..4g+3

	// host register access
	typedef logic [31:0]  reg_word_t;
	typedef logic [15:0]  host_addr_t;    // 15:12 MAC select, 11:0 offset
	typedef logic [3:0]   sys_addr_t;     // strapped MAC number

endpackage

`default_nettype wire

/* source/lmac_rx_monitor_top.sv */
// receive frame delimiter monitor with its host read port, all on clk
// no back-pressure, reads may start every clock
`default_nettype none

module lmac_rx_monitor_top
	import lmac_pkg::*;
(
	input  logic        clk,
	input  logic        reset_,
	input  logic        mode_25g,
	input  cgmii_data_t cgmii_rxd,
	input  cgmii_ctrl_t cgmii_rxc,
	input  logic        fmac_rxd_en,
	input  reg_word_t   fmac_ctrl,
	input  logic        reg_rd_start,
	input  host_addr_t  host_addr,
	input  sys_addr_t   sys_addr,
	output logic        reg_rd_done,
	output reg_word_t   fmac_regdout
);

	lane_group_t sof_valid;
	lane_group_t sof_misaligned;
	logic        eof_seen;
	reg_word_t   bad_sof_reg;
	logic        rx_auto_clr;

	cgmii_delim_detect i_delim_detect (
		.clk            (clk),
		.reset_         (reset_),
		.mode_25g       (mode_25g),
		.cgmii_rxd      (cgmii_rxd),
		.cgmii_rxc      (cgmii_rxc),
		.sof_valid      (sof_valid),
		.sof_misaligned (sof_misaligned),
		.eof_seen       (eof_seen)
	);

	frame_delim_checker i_delim_checker (
		.clk            (clk),
		.reset_         (reset_),
		.fmac_rxd_en    (fmac_rxd_en),
		.rx_auto_clr    (rx_auto_clr),
		.sof_valid      (sof_valid),
		.sof_misaligned (sof_misaligned),
		.eof_seen       (eof_seen),
		.bad_sof_reg    (bad_sof_reg)
	);

	mac_reg_read i_reg_read (
		.clk            (clk),
		.reset_         (reset_),
		.reg_rd_start   (reg_rd_start),
		.host_addr      (host_addr),
		.sys_addr       (sys_addr),
		.fmac_ctrl      (fmac_ctrl),
		.bad_sof_reg    (bad_sof_reg),
		.rx_auto_clr    (rx_auto_clr),
		.reg_rd_done    (reg_rd_done),
		.fmac_regdout   (fmac_regdout)
	);

endmodule

`default_nettype wire

/* source/mac_reg_read.sv */
// host read port, data and done return five clocks after the start pulse
// only the control and bad frame offsets decode, other offsets and other MACs read zero
`default_nettype none
`include "lmac_defs.svh"

module mac_reg_read
	import lmac_pkg::*;
(
	input  logic       clk,
	input  logic       reset_,
	input  logic       reg_rd_start,   // one clock pulse
	input  host_addr_t host_addr,      // sampled with the start
	input  sys_addr_t  sys_addr,
	input  reg_word_t  fmac_ctrl,      // level
	input  reg_word_t  bad_sof_reg,
	output logic       rx_auto_clr,
	output logic       reg_rd_done,    // one clock pulse
	output reg_word_t  fmac_regdout    // held until the next done
);

	reg_word_t fmac_ctrl_q;            // rebuffered control word
	logic      mac_hit;
	reg_word_t rd_word;
	logic      pipe_valid;
	reg_word_t pipe_data;

	always_ff @(posedge clk) begin
		if (!reset_)
			fmac_ctrl_q <= '0;
		else
			fmac_ctrl_q <= fmac_ctrl;
	end

	assign rx_auto_clr = fmac_ctrl_q[`LMAC_CTRL_RX_AUTO_CLR];

	// address decode, picked on the start clock
	assign mac_hit = (host_addr[15:12] == sys_addr);

	always_comb begin
		rd_word = '0;
		if (mac_hit) begin
			case (host_addr[11:0])
				`LMAC_REG_BAD_SOF: rd_word = bad_sof_reg;
				`LMAC_REG_CTRL:    rd_word = fmac_ctrl_q;   // readback of the buffered copy
				default:           rd_word = '0;
			endcase
		end
	end

	// four clocks in the pipe, one in the output stage
	delay_pipe #(
		.payload_t (reg_word_t),
		.DEPTH     (`LMAC_RD_LATENCY - 1)
	) i_rd_pipe (
		.clk       (clk),
		.reset_    (reset_),
		.in_valid  (reg_rd_start),
		.in_data   (rd_word),
		.out_valid (pipe_valid),
		.out_data  (pipe_data)
	);

	always_ff @(posedge clk) begin
		if (!reset_) begin
			reg_rd_done  <= 1'b0;
			fmac_regdout <= '0;
		end else begin
			reg_rd_done <= pipe_valid;
			if (pipe_valid)
				fmac_regdout <= pipe_data;          // hold between reads
		end
	end

	// fixed read latency across the pipe and output stage
	a_done_after_start: assert property (
		@(posedge clk) disable iff (!reset_)
		reg_rd_done |-> $past(reg_rd_start, `LMAC_RD_LATENCY)
	) else $error("reg_rd_done without a start five clocks earlier");

endmodule

`default_nettype wire

/* tb.f */
+incdir+source
source/lmac_pkg.sv
source/delay_pipe.sv
source/cgmii_delim_detect.sv
source/frame_delim_checker.sv
source/mac_reg_read.sv
source/lmac_rx_monitor_top.sv
sim/tb_lmac_rx_monitor.sv
